//--- bench/nexys_top_input.txt
# kind addr data sel expected, all hex, addr is a byte address
# W write, R read, G SD pins, I SD inputs, F video fill of data words, S scan passes
G 0000 0000 0 0000
W 0100 1234 3 0000
R 0100 0000 3 1234
W 0100 AAFF 1 0000
R 0100 0000 3 12FF
W 0100 56CC 2 0000
R 0100 0000 3 56FF
W 7FFE BEEF 3 0000
R 7FFE 0000 3 BEEF
W B010 1235 3 0000
R B010 0000 3 1235
G 0000 0000 0 0005
W B010 000A 3 0000
G 0000 0000 0 000A
W B012 FFFF 3 0000
R B010 0000 3 000A
I B012 0000 3 0000
I B012 0000 3 0000
I B012 0000 3 0000
W 0000 1111 3 0000
W 8000 FFFF 3 0000
R 8000 0000 3 0000
W B000 FFFF 3 0000
R B000 0000 3 0000
R 0000 0000 3 1111
F C000 0100 3 0000
W C002 00EE 1 0000
R C002 0000 3 5BEE
S 0000 0000 0 0000

//--- bench/nexys_top_sva.sv
module nexys_top_sva (
	input logic              clk_i,
	input logic              arst_n_i,
	input logic              prog_stb_i,
	input logic              gpio_stb_i,
	input logic              vram_stb_i,
	input logic              prog_ack_i,
	input logic              gpio_ack_i,
	input logic              mem_stb_i,
	input logic              mem_ack_i,
	input logic              cpu_ack_i,
	input logic              scan_ack_i,
	input nexys_pkg::vaddr_t scan_adr_i,
	input logic              vid_valid_i,
	input logic              vid_first_i
);

	int assert_fails = 0;

	// Registered target acks only while the strobe they answer is still held
	ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(!prog_ack_i || prog_stb_i)
		&& (!gpio_ack_i || gpio_stb_i)
		&& (!mem_ack_i || mem_stb_i))
		else begin
			$error("target ack outside an active strobe");
			assert_fails++;
		end

	one_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0({prog_stb_i, gpio_stb_i, vram_stb_i}))
		else begin
			$error("decoder raised more than one target strobe");
			assert_fails++;
		end

	// Every video RAM ack goes to exactly one master
	one_grant_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		mem_ack_i |-> (cpu_ack_i ^ scan_ack_i))
		else begin
			$error("video RAM ack not routed to exactly one master");
			assert_fails++;
		end

	// Word 0 comes out once the fetcher has moved on to word 1
	first_with_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		vid_first_i |-> (vid_valid_i && scan_adr_i == 1))
		else begin
			$error("vid_first_o without vid_valid_o on word 0");
			assert_fails++;
		end

endmodule

//--- bench/nexys_top_tb.sv
module nexys_top_tb;
	import nexys_pkg::*;

	logic  clk = 1'b0;
	logic  arst_n;
	logic  bus_cyc, bus_stb, bus_we, bus_ack;
	addr_t bus_adr;
	sel_t  bus_sel;
	data_t bus_wdat, bus_rdat, vid_word;
	logic  sd_miso, sd_wp, sd_cd, sd_clk, sd_mosi, sd_cs, sd_led;
	logic  vid_valid, vid_first;

	string       op_kind[$];
	logic [15:0] op_adr[$];
	data_t       op_dat[$];
	sel_t        op_sel[$];
	data_t       op_exp[$];
	data_t       vref [VRAM_WORDS];	// Mirror of CPU video writes
	int op_count, wd_cycles, tests, failed, errors;
	int scan_passes, scan_idx;
	bit test_bad, scan_on, synced;

	always #5 clk = ~clk;

	nexys_top nexys_top_i (
		.clk_i(clk), .arst_n_i(arst_n),
		.cyc_i(bus_cyc), .stb_i(bus_stb), .we_i(bus_we), .adr_i(bus_adr),
		.sel_i(bus_sel), .dat_i(bus_wdat), .dat_o(bus_rdat), .ack_o(bus_ack),
		.sd_miso_i(sd_miso), .sd_wp_i(sd_wp), .sd_cd_i(sd_cd),
		.sd_clk_o(sd_clk), .sd_mosi_o(sd_mosi), .sd_cs_o(sd_cs), .sd_led_o(sd_led),
		.vid_word_o(vid_word), .vid_valid_o(vid_valid), .vid_first_o(vid_first)
	);

	bind nexys_top nexys_top_sva nexys_top_sva_i (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.prog_stb_i(prog_stb), .gpio_stb_i(gpio_stb), .vram_stb_i(vram_stb),
		.prog_ack_i(prog_ack), .gpio_ack_i(gpio_ack),
		.mem_stb_i(mem_stb), .mem_ack_i(mem_ack),
		.cpu_ack_i(vram_ack), .scan_ack_i(scan_ack), .scan_adr_i(scan_adr),
		.vid_valid_i(vid_valid_o), .vid_first_i(vid_first_o)
	);

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	// Spreads every address bit over both bytes
	function automatic data_t vid_pattern(input vaddr_t a);
		data_t w;
		w = a;
		return (w * 16'h0101) ^ 16'h5AC3;
	endfunction

	task automatic load_ops;
		int fd, n;
		string kind, rest;
		logic [15:0] a, d, s, e;
		fd = $fopen("bench/nexys_top_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/nexys_top_input.txt");
			errors++;
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind.substr(0, 0) == "#") begin
					n = $fgets(rest, fd);	// Comment line
				end else begin
					n = $fscanf(fd, "%h %h %h %h", a, d, s, e);
					if (n != 4) begin
						$display("Malformed operation line after kind %s", kind);
						errors++;
					end else begin
						op_kind.push_back(kind);
						op_adr.push_back(a);
						op_dat.push_back(d);
						op_sel.push_back(s[1:0]);
						op_exp.push_back(e);
						op_count += (kind == "F") ? 2 * d : 1;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Classic cycle; stb is held through the clock edge that ends the ack
	task automatic bus_access(input string name, input logic write, input logic [15:0] baddr,
			input sel_t sel, input data_t wdat, output data_t rdat);
		int waited;
		bit acked;
		waited = 0;
		acked = 1'b0;
		rdat = '0;
		@(negedge clk);
		bus_cyc = 1'b1;
		bus_stb = 1'b1;
		bus_we = write;
		bus_adr = baddr[15:1];
		bus_sel = sel;
		bus_wdat = wdat;
		while (!acked && waited < 16) begin
			@(negedge clk);
			waited++;
			acked = bus_ack;
		end
		if (acked) begin
			rdat = bus_rdat;
		end else begin
			$display("No ack from address %h in %s after %0d cycles", baddr, name, waited);
			errors++;
			test_bad = 1'b1;
		end
		@(negedge clk);
		bus_cyc = 1'b0;
		bus_stb = 1'b0;
		bus_we = 1'b0;
		if (write && acked && baddr[15:14] == VRAM_REGION) begin
			if (sel[0]) vref[baddr[13:1]][7:0] = wdat[7:0];
			if (sel[1]) vref[baddr[13:1]][15:8] = wdat[15:8];
		end
	endtask

	task automatic sample_inputs(input string name, input logic [15:0] baddr);
		logic [2:0] lv;
		gpio_t exp;
		data_t rd;
		lv = $urandom_range(0, 7);
		@(negedge clk);
		sd_miso = lv[2];
		sd_wp = lv[1];
		sd_cd = lv[0];
		repeat (3) @(negedge clk);	// Past the two-stage synchronizer
		bus_access(name, 1'b0, baddr, 2'b11, '0, rd);
		exp = '0;
		exp[SD_MISO_BIT] = lv[2];
		exp[SD_WP_BIT] = lv[1];
		exp[SD_CD_BIT] = lv[0];
		check_gpio(name, exp, rd);
	endtask

	task automatic fill_video(input string name, input logic [15:0] base, input int count);
		logic [15:0] ba;
		data_t rd;
		for (int k = 0; k < count; k++) begin
			ba = base + (k << 1);
			bus_access(name, 1'b1, ba, 2'b11, vid_pattern(ba[13:1]), rd);
		end
		for (int k = 0; k < count; k++) begin
			ba = base + (k << 1);
			bus_access(name, 1'b0, ba, 2'b11, '0, rd);
			check_data($sformatf("%s word %0d", name, k), vid_pattern(ba[13:1]), rd);
		end
	endtask

	task automatic watch_scan;
		scan_passes = 0;
		synced = 1'b0;
		scan_on = 1'b1;
		while (scan_passes < 3) @(negedge clk);	// Marker pass plus two full passes
		scan_on = 1'b0;
	endtask

	task automatic run_op(input int i, input string name);
		data_t rd;
		gpio_t pins;
		case (op_kind[i])
			"W": bus_access(name, 1'b1, op_adr[i], op_sel[i], op_dat[i], rd);
			"R": begin
				bus_access(name, 1'b0, op_adr[i], op_sel[i], '0, rd);
				check_data(name, op_exp[i], rd);
			end
			"G": begin
				pins = '0;
				pins[SD_CLK_BIT] = sd_clk;
				pins[SD_MOSI_BIT] = sd_mosi;
				pins[SD_CS_BIT] = sd_cs;
				pins[SD_LED_BIT] = sd_led;
				check_gpio(name, op_exp[i], pins);
			end
			"I": sample_inputs(name, op_adr[i]);
			"F": fill_video(name, op_adr[i], op_dat[i]);
			"S": watch_scan();
			default: begin
				$display("Unknown operation kind %s in %s", op_kind[i], name);
				errors++;
				test_bad = 1'b1;
			end
		endcase
	endtask

	// Stream checker, locks on the first marker after arming
	always @(negedge clk) begin
		if (scan_on && vid_valid) begin
			if (vid_first && !synced) begin
				synced = 1'b1;
				scan_idx = 0;
			end
			if (synced) begin
				check_bit($sformatf("scan marker %0d", scan_idx), scan_idx == 0, vid_first);
				check_data($sformatf("scan word %0d", scan_idx), vref[scan_idx], vid_word);
				if (scan_idx == 0) scan_passes++;
				scan_idx = (scan_idx + 1) % SCAN_WORDS;
			end
		end
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout, the run did not complete within %0d cycles", wd_cycles);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int seed_ret;
		string name;
		arst_n = 1'b0;
		bus_cyc = 1'b0;
		bus_stb = 1'b0;
		bus_we = 1'b0;
		bus_adr = '0;
		bus_sel = '0;
		bus_wdat = '0;
		sd_miso = 1'b0;
		sd_wp = 1'b0;
		sd_cd = 1'b0;
		seed_ret = $urandom(32'h844d6523);
		load_ops();
		wd_cycles = op_count * 20 + 3 * SCAN_WORDS * 4 + 10;
		repeat (10) @(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < op_kind.size(); i++) begin
			repeat ($urandom_range(0, 3)) @(negedge clk);	// Idle gap
			name = $sformatf("op%0d %s %h", i, op_kind[i], op_adr[i]);
			test_bad = 1'b0;
			run_op(i, name);
			tests++;
			if (test_bad) begin
				failed++;
				$display("FAIL %s", name);
			end else begin
				$display("PASS %s", name);
			end
		end
		errors += nexys_top_i.nexys_top_sva_i.assert_fails;
		$display("Tests run %0d, tests failed %0d, check errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- nexys_top.f
source/nexys_pkg.sv
source/bus_decoder.sv
source/wb_ram.sv
source/gpio_port.sv
source/vram_arbiter.sv
source/scan_fetch.sv
source/nexys_top.sv
bench/nexys_top_sva.sv
bench/nexys_top_tb.sv

//--- source/bus_decoder.sv
module bus_decoder (
	input  logic             cyc_i,
	input  logic             stb_i,
	input  nexys_pkg::addr_t adr_i,

	output logic             prog_stb_o,
	output logic             gpio_stb_o,
	output logic             vram_stb_o,

	input  nexys_pkg::data_t prog_dat_i,
	input  nexys_pkg::data_t gpio_dat_i,
	input  nexys_pkg::data_t vram_dat_i,
	input  logic             prog_ack_i,
	input  logic             gpio_ack_i,
	input  logic             vram_ack_i,

	output nexys_pkg::data_t dat_o,
	output logic             ack_o
);
	import nexys_pkg::*;

	logic  bus_cycle;
	logic  none_hit;
	data_t prog_mask;
	data_t gpio_mask;
	data_t vram_mask;

	assign bus_cycle = cyc_i & stb_i;

	// Regions are disjoint, so at most one strobe is high
	assign prog_stb_o = bus_cycle & (adr_i[15] == PROG_REGION);
	assign gpio_stb_o = bus_cycle & (adr_i[15:4] == GPIO_PAGE);
	assign vram_stb_o = bus_cycle & (adr_i[15:14] == VRAM_REGION);

	assign none_hit = ~(prog_stb_o | gpio_stb_o | vram_stb_o);

	assign prog_mask = {$bits(data_t){prog_stb_o}};
	assign gpio_mask = {$bits(data_t){gpio_stb_o}};
	assign vram_mask = {$bits(data_t){vram_stb_o}};

	// Unmapped reads come back as zero since every mask is clear
	assign dat_o = (prog_mask & prog_dat_i)
		| (gpio_mask & gpio_dat_i)
		| (vram_mask & vram_dat_i);

	assign ack_o = (prog_stb_o & prog_ack_i)
		| (gpio_stb_o & gpio_ack_i)
		| (vram_stb_o & vram_ack_i)
		| (bus_cycle & none_hit);	// Unmapped, same-cycle ack

endmodule

//--- source/gpio_port.sv
module gpio_port (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  logic             cyc_i,
	input  logic             stb_i,
	input  logic             we_i,
	input  nexys_pkg::addr_t adr_i,
	input  nexys_pkg::data_t dat_i,
	output nexys_pkg::data_t dat_o,
	output logic             ack_o,
	input  nexys_pkg::gpio_t port_i,
	output nexys_pkg::gpio_t port_o
);
	import nexys_pkg::*;

	gpio_t      out_q;
	gpio_t      sync1_q;
	gpio_t      sync2_q;
	logic [2:0] ofs;
	logic       access;
	logic       seen_q;
	logic       ack_q;

	assign ofs    = adr_i[3:1];
	assign access = cyc_i & stb_i & ~seen_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_q  <= '0;
			seen_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			seen_q <= cyc_i & stb_i;
			ack_q  <= access;
			if (access && we_i && ofs == GPIO_OUT_OFS) out_q <= dat_i;
		end
	end

	// Pins are asynchronous to the bus clock
	always_ff @(posedge clk_i) begin
		sync1_q <= port_i;
		sync2_q <= sync1_q;
	end

	always_comb begin
		case (ofs)
			GPIO_OUT_OFS: dat_o = out_q;
			GPIO_IN_OFS:  dat_o = sync2_q;
			default:      dat_o = '0;	// Spare words in the page
		endcase
	end

	assign ack_o  = ack_q;
	assign port_o = out_q;

endmodule

//--- source/nexys_pkg.sv
package nexys_pkg;

	typedef logic [15:1] addr_t;	// CPU word address
	typedef logic [15:0] data_t;
	typedef logic [1:0]  sel_t;
	typedef logic [12:0] vaddr_t;	// Video RAM word index
	typedef logic [15:0] gpio_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_CPU,
		ARB_SCAN
	} arb_state_t;

	localparam int PROG_WORDS = 16384;
	localparam int VRAM_WORDS = 8192;
	localparam int SCAN_WORDS = 256;	// Short pass for simulation

	// Address map on the upper address bits
	localparam logic        PROG_REGION = 1'b0;	// 0000-7FFF
	localparam logic [1:0]  VRAM_REGION = 2'b11;	// C000-FFFF
	localparam logic [11:0] GPIO_PAGE   = 12'hB01;

	// Word offsets inside the port page
	localparam logic [2:0] GPIO_OUT_OFS = 3'd0;
	localparam logic [2:0] GPIO_IN_OFS  = 3'd1;

	// Output word
	localparam int SD_CLK_BIT  = 3;
	localparam int SD_MOSI_BIT = 2;
	localparam int SD_CS_BIT   = 1;
	localparam int SD_LED_BIT  = 0;

	// Input word
	localparam int SD_MISO_BIT = 2;
	localparam int SD_WP_BIT   = 1;
	localparam int SD_CD_BIT   = 0;

endpackage

//--- source/nexys_top.sv
module nexys_top (
	input  logic             clk_i,
	input  logic             arst_n_i,

	input  logic             cyc_i,
	input  logic             stb_i,
	input  logic             we_i,
	input  nexys_pkg::addr_t adr_i,
	input  nexys_pkg::sel_t  sel_i,
	input  nexys_pkg::data_t dat_i,
	output nexys_pkg::data_t dat_o,
	output logic             ack_o,

	input  logic             sd_miso_i,
	input  logic             sd_wp_i,
	input  logic             sd_cd_i,
	output logic             sd_clk_o,
	output logic             sd_mosi_o,
	output logic             sd_cs_o,
	output logic             sd_led_o,

	output nexys_pkg::data_t vid_word_o,
	output logic             vid_valid_o,
	output logic             vid_first_o
);
	import nexys_pkg::*;

	logic   prog_stb;
	logic   gpio_stb;
	logic   vram_stb;
	logic   prog_ack;
	logic   gpio_ack;
	logic   vram_ack;
	data_t  prog_dat;
	data_t  gpio_dat;
	data_t  vram_dat;
	gpio_t  gpio_in;
	gpio_t  gpio_out;

	logic   mem_cyc;
	logic   mem_stb;
	logic   mem_we;
	logic   mem_ack;
	vaddr_t mem_adr;
	sel_t   mem_sel;
	data_t  mem_wdat;
	data_t  mem_rdat;

	logic   scan_cyc;
	logic   scan_stb;
	logic   scan_ack;
	vaddr_t scan_adr;
	data_t  scan_dat;

	// SD pins on the port words
	always_comb begin
		gpio_in = '0;
		gpio_in[SD_MISO_BIT] = sd_miso_i;
		gpio_in[SD_WP_BIT]   = sd_wp_i;
		gpio_in[SD_CD_BIT]   = sd_cd_i;
	end

	assign sd_clk_o  = gpio_out[SD_CLK_BIT];
	assign sd_mosi_o = gpio_out[SD_MOSI_BIT];
	assign sd_cs_o   = gpio_out[SD_CS_BIT];
	assign sd_led_o  = gpio_out[SD_LED_BIT];

	bus_decoder bus_decoder_i (
		.cyc_i(cyc_i), .stb_i(stb_i), .adr_i(adr_i),
		.prog_stb_o(prog_stb), .gpio_stb_o(gpio_stb), .vram_stb_o(vram_stb),
		.prog_dat_i(prog_dat), .gpio_dat_i(gpio_dat), .vram_dat_i(vram_dat),
		.prog_ack_i(prog_ack), .gpio_ack_i(gpio_ack), .vram_ack_i(vram_ack),
		.dat_o(dat_o), .ack_o(ack_o)
	);

	wb_ram #(.words(PROG_WORDS)) prog_ram_i (
		.clk_i(clk_i), .cyc_i(cyc_i), .stb_i(prog_stb), .we_i(we_i),
		.adr_i(adr_i[14:1]), .sel_i(sel_i), .dat_i(dat_i),
		.dat_o(prog_dat), .ack_o(prog_ack)
	);

	gpio_port gpio_port_i (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.cyc_i(cyc_i), .stb_i(gpio_stb), .we_i(we_i), .adr_i(adr_i),
		.dat_i(dat_i), .dat_o(gpio_dat), .ack_o(gpio_ack),
		.port_i(gpio_in), .port_o(gpio_out)
	);

	vram_arbiter vram_arbiter_i (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.cpu_cyc_i(cyc_i), .cpu_stb_i(vram_stb), .cpu_we_i(we_i),
		.cpu_adr_i(adr_i[13:1]), .cpu_sel_i(sel_i), .cpu_dat_i(dat_i),
		.cpu_dat_o(vram_dat), .cpu_ack_o(vram_ack),
		.scan_cyc_i(scan_cyc), .scan_stb_i(scan_stb), .scan_adr_i(scan_adr),
		.scan_dat_o(scan_dat), .scan_ack_o(scan_ack),
		.mem_cyc_o(mem_cyc), .mem_stb_o(mem_stb), .mem_we_o(mem_we),
		.mem_adr_o(mem_adr), .mem_sel_o(mem_sel), .mem_dat_o(mem_wdat),
		.mem_dat_i(mem_rdat), .mem_ack_i(mem_ack)
	);

	wb_ram #(.words(VRAM_WORDS)) vid_ram_i (
		.clk_i(clk_i), .cyc_i(mem_cyc), .stb_i(mem_stb), .we_i(mem_we),
		.adr_i(mem_adr), .sel_i(mem_sel), .dat_i(mem_wdat),
		.dat_o(mem_rdat), .ack_o(mem_ack)
	);

	scan_fetch scan_fetch_i (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.cyc_o(scan_cyc), .stb_o(scan_stb), .adr_o(scan_adr),
		.dat_i(scan_dat), .ack_i(scan_ack),
		.vid_word_o(vid_word_o), .vid_valid_o(vid_valid_o), .vid_first_o(vid_first_o)
	);

endmodule

//--- source/scan_fetch.sv
module scan_fetch (
	input  logic              clk_i,
	input  logic              arst_n_i,
	output logic              cyc_o,
	output logic              stb_o,
	output nexys_pkg::vaddr_t adr_o,
	input  nexys_pkg::data_t  dat_i,
	input  logic              ack_i,
	output nexys_pkg::data_t  vid_word_o,
	output logic              vid_valid_o,
	output logic              vid_first_o
);
	import nexys_pkg::*;

	vaddr_t adr_q;
	data_t  word_q;
	logic   stb_q;
	logic   valid_q;
	logic   first_q;
	logic   done;

	assign done = stb_q & ack_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			adr_q   <= '0;
			stb_q   <= 1'b0;
			valid_q <= 1'b0;
			first_q <= 1'b0;
		end else begin
			valid_q <= done;
			first_q <= done & (adr_q == '0);
			if (done) begin
				stb_q <= 1'b0;	// One low cycle after each ack
				adr_q <= (adr_q == vaddr_t'(SCAN_WORDS - 1)) ? '0 : adr_q + 1'b1;
			end else begin
				stb_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (done) word_q <= dat_i;
	end

	assign cyc_o       = stb_q;
	assign stb_o       = stb_q;
	assign adr_o       = adr_q;
	assign vid_word_o  = word_q;
	assign vid_valid_o = valid_q;
	assign vid_first_o = first_q;

endmodule

//--- source/vram_arbiter.sv
module vram_arbiter (
	input  logic              clk_i,
	input  logic              arst_n_i,

	input  logic              cpu_cyc_i,
	input  logic              cpu_stb_i,
	input  logic              cpu_we_i,
	input  nexys_pkg::vaddr_t cpu_adr_i,
	input  nexys_pkg::sel_t   cpu_sel_i,
	input  nexys_pkg::data_t  cpu_dat_i,
	output nexys_pkg::data_t  cpu_dat_o,
	output logic              cpu_ack_o,

	input  logic              scan_cyc_i,
	input  logic              scan_stb_i,
	input  nexys_pkg::vaddr_t scan_adr_i,
	output nexys_pkg::data_t  scan_dat_o,
	output logic              scan_ack_o,

	output logic              mem_cyc_o,
	output logic              mem_stb_o,
	output logic              mem_we_o,
	output nexys_pkg::vaddr_t mem_adr_o,
	output nexys_pkg::sel_t   mem_sel_o,
	output nexys_pkg::data_t  mem_dat_o,
	input  nexys_pkg::data_t  mem_dat_i,
	input  logic              mem_ack_i
);
	import nexys_pkg::*;

	arb_state_t state_q;
	logic       cpu_req;
	logic       scan_req;

	assign cpu_req  = cpu_cyc_i & cpu_stb_i;
	assign scan_req = scan_cyc_i & scan_stb_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ARB_IDLE;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (scan_req) state_q <= ARB_SCAN;	// Scan wins a tie
					else if (cpu_req) state_q <= ARB_CPU;
				end
				ARB_CPU:  if (mem_ack_i || !cpu_req) state_q <= ARB_IDLE;
				ARB_SCAN: if (mem_ack_i || !scan_req) state_q <= ARB_IDLE;
				default:  state_q <= ARB_IDLE;
			endcase
		end
	end

	// Memory sees nothing while idle, so its strobe drops between grants
	always_comb begin
		mem_cyc_o = 1'b0;
		mem_stb_o = 1'b0;
		mem_we_o  = 1'b0;
		mem_adr_o = '0;
		mem_sel_o = '0;
		mem_dat_o = '0;
		case (state_q)
			ARB_CPU: begin
				mem_cyc_o = cpu_cyc_i;
				mem_stb_o = cpu_stb_i;
				mem_we_o  = cpu_we_i;
				mem_adr_o = cpu_adr_i;
				mem_sel_o = cpu_sel_i;
				mem_dat_o = cpu_dat_i;
			end
			ARB_SCAN: begin
				mem_cyc_o = scan_cyc_i;
				mem_stb_o = scan_stb_i;
				mem_adr_o = scan_adr_i;
				mem_sel_o = '1;	// Whole-word read
			end
			default: ;
		endcase
	end

	assign cpu_ack_o  = (state_q == ARB_CPU) & mem_ack_i;
	assign scan_ack_o = (state_q == ARB_SCAN) & mem_ack_i;
	assign cpu_dat_o  = (state_q == ARB_CPU) ? mem_dat_i : '0;
	assign scan_dat_o = (state_q == ARB_SCAN) ? mem_dat_i : '0;

endmodule

//--- source/wb_ram.sv
module wb_ram #(
	parameter int words = nexys_pkg::VRAM_WORDS
) (
	input  logic                     clk_i,
	input  logic                     cyc_i,
	input  logic                     stb_i,
	input  logic                     we_i,
	input  logic [$clog2(words)-1:0] adr_i,
	input  nexys_pkg::sel_t          sel_i,
	input  nexys_pkg::data_t         dat_i,
	output nexys_pkg::data_t         dat_o,
	output logic                     ack_o
);
	import nexys_pkg::*;

	data_t mem [words];
	data_t rd_q;
	logic  access;
	logic  seen_q;
	logic  ack_q;

	// First cycle of a strobe only
	assign access = cyc_i & stb_i & ~seen_q;

	always_ff @(posedge clk_i) begin
		seen_q <= cyc_i & stb_i;	// Clears once stb falls
		ack_q  <= access;
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			if (we_i) begin
				if (sel_i[0]) mem[adr_i][7:0] <= dat_i[7:0];
				if (sel_i[1]) mem[adr_i][15:8] <= dat_i[15:8];
			end
			rd_q <= mem[adr_i];
		end
	end

	assign dat_o = rd_q;
	assign ack_o = ack_q;

endmodule
